// File: lane_pkg.sv
package lane_pkg;

	////////////////////////////////////////////////////////////
	// Array geometry
	localparam int NUM_LANES = 4;
	localparam int REG_DEPTH = 16;				// Registers per lane
	localparam int DATA_W    = 32;
	localparam int IDX_W     = $clog2(REG_DEPTH);

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [IDX_W-1:0]  index_t;		// Wraps modulo REG_DEPTH

	typedef enum logic [3:0] {
		NOP     = 4'h0,
		ADD     = 4'h1,
		SUB     = 4'h2,
		MUL     = 4'h3,						// Low half of product
		MAD     = 4'h4,						// src1 * src2 + src3
		AND     = 4'h5,
		OR      = 4'h6,
		XOR     = 4'h7,
		MOV     = 4'h8,						// Copies src2
		CMPLT   = 4'h9,						// Signed less-than, also sets mask
		MASKALL = 4'hA						// Mask to 1, no write
	} op_t;

	typedef enum logic [1:0] {
		SEL_REG    = 2'd0,
		SEL_SCALAR = 2'd1,
		SEL_LEFT   = 2'd2						// Left neighbour's src1
	} src_sel_t;

	typedef struct packed {
		logic   lane_rel;						// Add lane number
		index_t idx;
	} operand_t;

	////////////////////////////////////////////////////////////
	// Broadcast command and lane results
	typedef struct packed {
		op_t      op;
		operand_t dst;
		operand_t src1;
		operand_t src2;
		operand_t src3;
		src_sel_t src2_sel;
		logic     masked;						// Honour lane mask
		index_t   window;						// Added to every index
		data_t    scalar;
	} command_t;

	typedef struct packed {
		logic   v;
		index_t idx;
		data_t  data;
	} wb_t;

	////////////////////////////////////////////////////////////
	// Stage registers inside a lane
	typedef struct packed {
		logic     v;
		command_t cmd;
	} stage_idx_t;

	// Control carried through index and read stages
	typedef struct packed {
		logic     v;
		op_t      op;
		src_sel_t src2_sel;
		data_t    scalar;
	} stage_ctl_t;

	typedef struct packed {
		logic     v;
		op_t      op;
		src_sel_t src2_sel;
		logic     dst_we;
		index_t   dst_idx;
		data_t    src1_data;
		data_t    src2_data;
		data_t    src3_data;
	} stage_rr_t;

	typedef struct packed {
		logic   v;
		op_t    op;
		logic   dst_we;
		index_t dst_idx;
		data_t  src1_data;
		data_t  src2_data;
		data_t  src3_data;
	} stage_exe_t;

endpackage

// File: index_unit.sv
`timescale 1ns/1ps

module index_unit
	import lane_pkg::*;
#(
	parameter int LANE_ID = 0
)(
	input  logic     clock,
	input  logic     reset,
	input  logic     req,
	input  operand_t operand,
	input  index_t   window,
	input  logic     gate,			// Destination of a masked command
	input  logic     mask,
	output logic     req_out,
	output index_t   index
);

	index_t lane_off;
	index_t phys;

	// Lane offset only for lane-relative operands
	assign lane_off = operand.lane_rel ? index_t'(LANE_ID) : '0;

	// 4-bit sum wraps modulo 16
	assign phys = operand.idx + window + lane_off;

	always_ff @(posedge clock) begin
		if (reset) begin
			req_out <= 1'b0;
		end else begin
			req_out <= req & (~gate | mask);
		end
	end

	always_ff @(posedge clock) begin
		index <= phys;
	end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file
	import lane_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   we,
	input  index_t windex,
	input  data_t  wdata,
	input  index_t raddr1,
	input  index_t raddr2,
	output data_t  rdata1,
	output data_t  rdata2
);

	data_t mem [REG_DEPTH];

	logic  hit1;
	logic  hit2;

	// Same-cycle write seen by a read of the same entry
	assign hit1 = we & (windex == raddr1);
	assign hit2 = we & (windex == raddr2);

	////////////////////////////////////////////////////////////
	// Write port
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < REG_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[windex] <= wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Registered read ports
	always_ff @(posedge clock) begin
		rdata1 <= hit1 ? wdata : mem[raddr1];
		rdata2 <= hit2 ? wdata : mem[raddr2];
	end

endmodule

// File: operand_network.sv
`timescale 1ns/1ps

module operand_network
	import lane_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  stage_rr_t  stage_in,
	input  data_t      scalar,
	input  data_t      left_data,		// src1 of lane (k-1) mod 4
	output stage_exe_t stage_out
);

	data_t      src2_pick;
	stage_exe_t next;

	// Second operand source
	always_comb begin
		case (stage_in.src2_sel)
			SEL_REG:    src2_pick = stage_in.src2_data;
			SEL_SCALAR: src2_pick = scalar;
			SEL_LEFT:   src2_pick = left_data;
			default:    src2_pick = '0;
		endcase
	end

	always_comb begin
		next.v         = stage_in.v;
		next.op        = stage_in.op;
		next.dst_we    = stage_in.dst_we;
		next.dst_idx   = stage_in.dst_idx;
		next.src1_data = stage_in.src1_data;
		next.src2_data = src2_pick;
		next.src3_data = stage_in.src3_data;
	end

	////////////////////////////////////////////////////////////
	// Operand set register
	always_ff @(posedge clock) begin
		stage_out <= next;
		if (reset) begin
			stage_out.v      <= 1'b0;
			stage_out.dst_we <= 1'b0;
		end
	end

endmodule

// File: vmath_unit.sv
`timescale 1ns/1ps

module vmath_unit
	import lane_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  stage_exe_t stage_in,
	output wb_t        wb,
	output logic       done,
	output logic       cond_we,
	output logic       cond,
	output logic       mask_all
);

	data_t result;
	logic  writes;				// Opcode has a register result
	logic  less;

	assign less = $signed(stage_in.src1_data) < $signed(stage_in.src2_data);

	always_comb begin
		result = '0;
		writes = 1'b1;
		case (stage_in.op)
			ADD:   result = stage_in.src1_data + stage_in.src2_data;
			SUB:   result = stage_in.src1_data - stage_in.src2_data;
			MUL:   result = stage_in.src1_data * stage_in.src2_data;
			MAD: begin
				result = stage_in.src1_data * stage_in.src2_data + stage_in.src3_data;
			end
			AND:   result = stage_in.src1_data & stage_in.src2_data;
			OR:    result = stage_in.src1_data | stage_in.src2_data;
			XOR:   result = stage_in.src1_data ^ stage_in.src2_data;
			MOV:   result = stage_in.src2_data;
			CMPLT: result = data_t'(less);
			default: begin		// NOP, MASKALL
				writes = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Result register
	always_ff @(posedge clock) begin
		if (reset) begin
			wb.v     <= 1'b0;
			done     <= 1'b0;
			cond_we  <= 1'b0;
			mask_all <= 1'b0;
		end else begin
			wb.v     <= stage_in.v & stage_in.dst_we & writes;
			done     <= stage_in.v;			// Commit even when masked off
			// A masked-off lane keeps its mask on a compare
			cond_we  <= stage_in.v & stage_in.dst_we & (stage_in.op == CMPLT);
			mask_all <= stage_in.v & (stage_in.op == MASKALL);
		end
	end

	always_ff @(posedge clock) begin
		wb.idx  <= stage_in.dst_idx;
		wb.data <= result;
		cond    <= less;
	end

endmodule

// File: mask_reg.sv
`timescale 1ns/1ps

module mask_reg
	import lane_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic cond_we,
	input  logic cond,
	input  logic mask_all,
	input  wb_t  result,
	output logic mask,
	output logic zero,
	output logic negative
);

	// Lane enable
	always_ff @(posedge clock) begin
		if (reset) begin
			mask <= 1'b1;
		end else if (mask_all) begin
			mask <= 1'b1;
		end else if (cond_we) begin
			mask <= cond;
		end
	end

	////////////////////////////////////////////////////////////
	// Flags of the last written result
	always_ff @(posedge clock) begin
		if (reset) begin
			zero     <= 1'b0;
			negative <= 1'b0;
		end else if (result.v) begin
			zero     <= (result.data == '0);
			negative <= result.data[DATA_W-1];
		end
	end

endmodule

// File: lane_unit.sv
`timescale 1ns/1ps

module lane_unit
	import lane_pkg::*;
#(
	parameter int LANE_ID = 0
)(
	input  logic     clock,
	input  logic     reset,
	input  logic     cmd_valid,
	input  command_t command,
	input  data_t    left_data,
	output data_t    neighbor_data,
	output logic     commit,
	output wb_t      wb,
	output logic     mask
);

	stage_idx_t cap;				// Command capture
	stage_ctl_t ix_ctl;
	stage_ctl_t rd_ctl;
	stage_rr_t  stage_rr;
	stage_exe_t stage_exe;

	logic       src1_req;
	logic       src2_req;
	logic       src3_req;
	logic       dst_req;
	logic       en1;
	logic       en2;
	logic       en3;
	logic       en_dst;
	index_t     idx1;
	index_t     idx2;
	index_t     idx3;
	index_t     idx_d;
	logic       rd_en1;
	logic       rd_en2;
	logic       rd_en3;
	logic       rd_dst_we;
	index_t     rd_dst_idx;
	data_t      rdata1;
	data_t      rdata2;
	data_t      rdata3;
	logic       cond_we;
	logic       cond;
	logic       mask_all;

	////////////////////////////////////////////////////////////
	// Capture, end of strobe cycle
	always_ff @(posedge clock) begin
		cap.cmd <= command;
		if (reset) begin
			cap.v <= 1'b0;
		end else begin
			cap.v <= cmd_valid;
		end
	end

	// Only read what the opcode uses
	assign src1_req = cap.v;
	assign src2_req = cap.v & (cap.cmd.src2_sel == SEL_REG);
	assign src3_req = cap.v & (cap.cmd.op == MAD);
	assign dst_req  = cap.v;

	////////////////////////////////////////////////////////////
	// Index stage
	index_unit #(.LANE_ID(LANE_ID)) idx_src1 (
		.clock   (clock),
		.reset   (reset),
		.req     (src1_req),
		.operand (cap.cmd.src1),
		.window  (cap.cmd.window),
		.gate    (1'b0),
		.mask    (mask),
		.req_out (en1),
		.index   (idx1)
	);

	index_unit #(.LANE_ID(LANE_ID)) idx_src2 (
		.clock   (clock),
		.reset   (reset),
		.req     (src2_req),
		.operand (cap.cmd.src2),
		.window  (cap.cmd.window),
		.gate    (1'b0),
		.mask    (mask),
		.req_out (en2),
		.index   (idx2)
	);

	index_unit #(.LANE_ID(LANE_ID)) idx_src3 (
		.clock   (clock),
		.reset   (reset),
		.req     (src3_req),
		.operand (cap.cmd.src3),
		.window  (cap.cmd.window),
		.gate    (1'b0),
		.mask    (mask),
		.req_out (en3),
		.index   (idx3)
	);

	// Mask decides write enable of masked commands
	index_unit #(.LANE_ID(LANE_ID)) idx_dst (
		.clock   (clock),
		.reset   (reset),
		.req     (dst_req),
		.operand (cap.cmd.dst),
		.window  (cap.cmd.window),
		.gate    (cap.cmd.masked),
		.mask    (mask),
		.req_out (en_dst),
		.index   (idx_d)
	);

	always_ff @(posedge clock) begin
		ix_ctl.op       <= cap.cmd.op;
		ix_ctl.src2_sel <= cap.cmd.src2_sel;
		ix_ctl.scalar   <= cap.cmd.scalar;
		if (reset) begin
			ix_ctl.v <= 1'b0;
		end else begin
			ix_ctl.v <= cap.v;
		end
	end

	////////////////////////////////////////////////////////////
	// Register read stage, both banks hold the same data
	reg_file bank_a (
		.clock  (clock),
		.reset  (reset),
		.we     (wb.v),
		.windex (wb.idx),
		.wdata  (wb.data),
		.raddr1 (idx1),
		.raddr2 (idx2),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	reg_file bank_b (
		.clock  (clock),
		.reset  (reset),
		.we     (wb.v),
		.windex (wb.idx),
		.wdata  (wb.data),
		.raddr1 (idx3),
		.raddr2 (idx3),
		.rdata1 (rdata3),
		.rdata2 ()
	);

	always_ff @(posedge clock) begin
		rd_ctl.op       <= ix_ctl.op;
		rd_ctl.src2_sel <= ix_ctl.src2_sel;
		rd_ctl.scalar   <= ix_ctl.scalar;
		rd_dst_idx      <= idx_d;
		if (reset) begin
			rd_ctl.v  <= 1'b0;
			rd_en1    <= 1'b0;
			rd_en2    <= 1'b0;
			rd_en3    <= 1'b0;
			rd_dst_we <= 1'b0;
		end else begin
			rd_ctl.v  <= ix_ctl.v;
			rd_en1    <= en1;
			rd_en2    <= en2;
			rd_en3    <= en3;
			rd_dst_we <= en_dst;
		end
	end

	// Unrequested operands read as zero
	always_comb begin
		stage_rr.v         = rd_ctl.v;
		stage_rr.op        = rd_ctl.op;
		stage_rr.src2_sel  = rd_ctl.src2_sel;
		stage_rr.dst_we    = rd_dst_we;
		stage_rr.dst_idx   = rd_dst_idx;
		stage_rr.src1_data = rd_en1 ? rdata1 : '0;
		stage_rr.src2_data = rd_en2 ? rdata2 : '0;
		stage_rr.src3_data = rd_en3 ? rdata3 : '0;
	end

	assign neighbor_data = stage_rr.src1_data;		// To right neighbour

	////////////////////////////////////////////////////////////
	// Operand network and execution
	operand_network network (
		.clock     (clock),
		.reset     (reset),
		.stage_in  (stage_rr),
		.scalar    (rd_ctl.scalar),
		.left_data (left_data),
		.stage_out (stage_exe)
	);

	vmath_unit math (
		.clock    (clock),
		.reset    (reset),
		.stage_in (stage_exe),
		.wb       (wb),
		.done     (commit),
		.cond_we  (cond_we),
		.cond     (cond),
		.mask_all (mask_all)
	);

	mask_reg lane_mask (
		.clock    (clock),
		.reset    (reset),
		.cond_we  (cond_we),
		.cond     (cond),
		.mask_all (mask_all),
		.result   (wb),
		.mask     (mask),
		.zero     (),
		.negative ()
	);

endmodule

// File: lane_array.sv
`timescale 1ns/1ps

module lane_array
	import lane_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 cmd_valid,
	input  command_t             command,
	output logic [NUM_LANES-1:0] commit,
	output wb_t  [NUM_LANES-1:0] wb,
	output logic [NUM_LANES-1:0] mask
);

	data_t ring [NUM_LANES];		// src1 value of each lane

	////////////////////////////////////////////////////////////
	// Lanes with the neighbour ring
	for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
		localparam int LEFT = (k + NUM_LANES - 1) % NUM_LANES;

		lane_unit #(.LANE_ID(k)) lane (
			.clock         (clock),
			.reset         (reset),
			.cmd_valid     (cmd_valid),		// Broadcast
			.command       (command),
			.left_data     (ring[LEFT]),		// Lane 0 takes lane 3
			.neighbor_data (ring[k]),
			.commit        (commit[k]),
			.wb            (wb[k]),
			.mask          (mask[k])
		);
	end

endmodule

// File: tb_lane_array.sv
`timescale 1ns/1ps

module tb_lane_array
	import lane_pkg::*;
();

	localparam int RESET_CYCLES    = 3;
	localparam int RAND_CMDS       = 48;
	localparam int ISSUED_CMDS     = 62 + RAND_CMDS;		// Directed plus random
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + ISSUED_CMDS + 100;

	// Expected lane outputs in the commit cycle
	typedef struct packed {
		int                   due;
		logic [NUM_LANES-1:0] mask_after;
		wb_t [NUM_LANES-1:0]  wb;
	} expect_t;

	typedef struct packed {
		int     due;					// First issue cycle that sees it
		int     lane;
		index_t idx;
		data_t  data;
	} reg_upd_t;

	typedef struct packed {
		int   due;
		int   lane;
		logic val;
	} mask_upd_t;

	logic                 clock = 1'b0;
	logic                 reset;
	logic                 cmd_valid;
	command_t             command;
	logic [NUM_LANES-1:0] commit;
	wb_t  [NUM_LANES-1:0] wb;
	logic [NUM_LANES-1:0] mask;

	int                   cyc = 0;
	logic [31:0]          lfsr = 32'h751593c0;
	data_t                mregs [NUM_LANES][REG_DEPTH];
	logic [NUM_LANES-1:0] mmask = '1;			// Seen by a new command
	logic [NUM_LANES-1:0] out_mask = '1;		// After last issued command
	logic [NUM_LANES-1:0] cur_mask = '1;		// Expected on the mask output
	expect_t              exp_q [$];
	reg_upd_t             reg_q [$];
	mask_upd_t            mask_q [$];
	int                   commit_errs = 0;
	int                   wb_errs = 0;
	int                   mask_errs = 0;

	lane_array UUT (
		.clock     (clock),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.command   (command),
		.commit    (commit),
		.wb        (wb),
		.mask      (mask)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cyc <= cyc + 1;
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic operand_t opnd(input logic rel, input int idx);
		operand_t o;
		o.lane_rel = rel;
		o.idx      = index_t'(idx);
		return o;
	endfunction

	function automatic operand_t rand_operand();
		logic [31:0] r;
		r = take_bits(5);
		return opnd(r[4], int'(r[3:0]));
	endfunction

	function automatic command_t build(input op_t op, input operand_t dst, input operand_t src1,
			input operand_t src2, input src_sel_t sel, input logic masked, input data_t scalar);
		command_t c;
		c          = '0;
		c.op       = op;
		c.dst      = dst;
		c.src1     = src1;
		c.src2     = src2;
		c.src2_sel = sel;
		c.masked   = masked;
		c.scalar   = scalar;
		return c;
	endfunction

	function automatic command_t random_cmd();
		command_t    c;
		logic [31:0] r;
		c          = '0;
		r          = take_bits(3);
		c.op       = op_t'(4'(1 + r % 7));		// ADD through XOR
		c.dst      = rand_operand();
		c.src1     = rand_operand();
		c.src2     = rand_operand();
		c.src3     = rand_operand();
		r          = take_bits(2);
		c.src2_sel = src_sel_t'(2'(r % 3));
		r          = take_bits(4);
		c.window   = r[3:0];
		c.scalar   = take_bits(32);
		return c;
	endfunction

	function automatic index_t phys(input operand_t o, input index_t w, input int k);
		int sum;
		sum = int'(o.idx) + int'(w) + (o.lane_rel ? k : 0);
		return index_t'(sum);					// Modulo 16
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model and strobe
	task automatic issue(input command_t c);
		data_t     s1 [NUM_LANES];
		data_t     s2;
		data_t     s3;
		data_t     res;
		logic      we;
		logic      writes;
		logic      less;
		expect_t   e;
		reg_upd_t  ru;
		mask_upd_t mu;
		while (reg_q.size() > 0 && reg_q[0].due <= cyc) begin
			ru = reg_q.pop_front();
			mregs[ru.lane][ru.idx] = ru.data;
		end
		while (mask_q.size() > 0 && mask_q[0].due <= cyc) begin
			mu = mask_q.pop_front();
			mmask[mu.lane] = mu.val;
		end
		for (int k = 0; k < NUM_LANES; k++) begin
			s1[k] = mregs[k][phys(c.src1, c.window, k)];
		end
		e     = '0;
		e.due = cyc + 5;
		for (int k = 0; k < NUM_LANES; k++) begin
			case (c.src2_sel)
				SEL_REG:    s2 = mregs[k][phys(c.src2, c.window, k)];
				SEL_SCALAR: s2 = c.scalar;
				SEL_LEFT:   s2 = s1[(k + NUM_LANES - 1) % NUM_LANES];	// Ring wrap
				default:    s2 = '0;
			endcase
			s3     = (c.op == MAD) ? mregs[k][phys(c.src3, c.window, k)] : '0;
			less   = $signed(s1[k]) < $signed(s2);
			writes = 1'b1;
			case (c.op)
				ADD:   res = s1[k] + s2;
				SUB:   res = s1[k] - s2;
				MUL:   res = s1[k] * s2;
				MAD:   res = s1[k] * s2 + s3;
				AND:   res = s1[k] & s2;
				OR:    res = s1[k] | s2;
				XOR:   res = s1[k] ^ s2;
				MOV:   res = s2;
				CMPLT: res = data_t'(less);
				default: begin
					res    = '0;
					writes = 1'b0;
				end
			endcase
			we           = !c.masked || mmask[k];
			e.wb[k].v    = we & writes;
			e.wb[k].idx  = phys(c.dst, c.window, k);
			e.wb[k].data = res;
			if (we & writes) begin
				ru.due  = cyc + 3;
				ru.lane = k;
				ru.idx  = e.wb[k].idx;
				ru.data = res;
				reg_q.push_back(ru);
			end
			if ((c.op == CMPLT && we) || c.op == MASKALL) begin
				mu.due      = cyc + 5;
				mu.lane     = k;
				mu.val      = (c.op == MASKALL) ? 1'b1 : less;
				out_mask[k] = mu.val;
				mask_q.push_back(mu);
			end
		end
		e.mask_after = out_mask;
		exp_q.push_back(e);
		cmd_valid = 1'b1;
		command   = c;
		@(negedge clock);
		cmd_valid = 1'b0;
		command   = '0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic read_back_all();
		for (int i = 0; i < REG_DEPTH; i++) begin
			issue(build(MOV, opnd(0, i), opnd(0, 0), opnd(0, i), SEL_REG, 1'b0, '0));
		end
	endtask

	task automatic show_mismatch(input string name, input logic [31:0] expv,
			input logic [31:0] act);
		$display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
			$time, name, expv, act);
	endtask

	////////////////////////////////////////////////////////////
	// Output checks on the falling edge
	always @(negedge clock) begin
		expect_t e;
		logic    has;
		logic    exp_v;
		e   = '0;
		has = 1'b0;
		if (!reset) begin
			if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
				e   = exp_q.pop_front();
				has = 1'b1;
			end
			for (int k = 0; k < NUM_LANES; k++) begin
				exp_v = has & e.wb[k].v;
				assert (commit[k] === has) else begin
					commit_errs++;
					show_mismatch($sformatf("commit[%0d]", k), 32'(has), 32'(commit[k]));
				end
				assert (wb[k].v === exp_v) else begin
					wb_errs++;
					show_mismatch($sformatf("wb[%0d].v", k), 32'(exp_v), 32'(wb[k].v));
				end
				if (exp_v) begin		// idx and data only mean something when written
					assert (wb[k].idx === e.wb[k].idx) else begin
						wb_errs++;
						show_mismatch($sformatf("wb[%0d].idx", k), 32'(e.wb[k].idx),
							32'(wb[k].idx));
					end
					assert (wb[k].data === e.wb[k].data) else begin
						wb_errs++;
						show_mismatch($sformatf("wb[%0d].data", k), e.wb[k].data, wb[k].data);
					end
				end
				assert (mask[k] === cur_mask[k]) else begin
					mask_errs++;
					show_mismatch($sformatf("mask[%0d]", k), 32'(cur_mask[k]), 32'(mask[k]));
				end
			end
			if (has) begin
				cur_mask = e.mask_after;		// Mask moves one cycle after commit
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		int total;
		for (int k = 0; k < NUM_LANES; k++) begin
			for (int i = 0; i < REG_DEPTH; i++) begin
				mregs[k][i] = '0;
			end
		end
		reset     = 1'b1;
		cmd_valid = 1'b0;
		command   = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		idle(2);

		read_back_all();						// All zero after reset
		for (int i = 0; i < REG_DEPTH; i++) begin
			issue(build(ADD, opnd(0, i), opnd(0, i), opnd(0, 0), SEL_SCALAR, 1'b0,
				take_bits(32)));
		end

		// Random back to back burst
		for (int n = 0; n < RAND_CMDS; n++) begin
			issue(random_cmd());
		end
		issue(build(MOV, opnd(0, 5), opnd(0, 0), opnd(0, 0), SEL_SCALAR, 1'b0, take_bits(32)));
		issue(build(MOV, opnd(1, 8), opnd(1, 3), opnd(0, 0), SEL_LEFT, 1'b0, '0));
		idle(5);

		// Lanes 2 and 3 drop out on the compare
		for (int i = 0; i < NUM_LANES; i++) begin
			issue(build(MOV, opnd(0, i), opnd(0, 0), opnd(0, 0), SEL_SCALAR, 1'b0, data_t'(i)));
		end
		idle(2);
		issue(build(CMPLT, opnd(0, 9), opnd(1, 0), opnd(0, 0), SEL_SCALAR, 1'b0, 32'd2));
		idle(4);
		issue(build(ADD, opnd(0, 10), opnd(0, 1), opnd(0, 0), SEL_SCALAR, 1'b1, take_bits(32)));
		idle(2);
		issue(build(MOV, opnd(0, 11), opnd(0, 0), opnd(0, 10), SEL_REG, 1'b0, '0));
		issue(build(MASKALL, opnd(0, 0), opnd(0, 0), opnd(0, 0), SEL_REG, 1'b0, '0));
		idle(4);
		issue(build(ADD, opnd(0, 10), opnd(0, 1), opnd(0, 0), SEL_SCALAR, 1'b1, take_bits(32)));
		idle(5);

		// Consumers at distance 2 and 3
		issue(build(MOV, opnd(0, 7), opnd(0, 0), opnd(0, 0), SEL_SCALAR, 1'b0, take_bits(32)));
		idle(1);
		issue(build(MOV, opnd(0, 8), opnd(0, 0), opnd(0, 7), SEL_REG, 1'b0, '0));
		issue(build(MOV, opnd(0, 12), opnd(0, 0), opnd(0, 7), SEL_REG, 1'b0, '0));
		idle(3);

		read_back_all();
		idle(8);
		total = commit_errs + wb_errs + mask_errs;
		$display("Errors: commit %0d, wb %0d, mask %0d, total %0d",
			commit_errs, wb_errs, mask_errs, total);
		if (total == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: flist.f
lane_pkg.sv
index_unit.sv
reg_file.sv
operand_network.sv
vmath_unit.sv
mask_reg.sv
lane_unit.sv
lane_array.sv
tb_lane_array.sv

// File: run.sh
#!/bin/sh
# Build and run the lane array testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_lane_array -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_lane_array > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
